// File: rtl/beats_settings.svh
`ifndef BEATS_SETTINGS_SVH
`define BEATS_SETTINGS_SVH

// ----------------------------------------------------------
// Beat buffer sizing
// ----------------------------------------------------------

// Buffer depth in beats, power of two
`define BEATS_DEPTH 64

// Width of one R data beat
`define BEATS_DATA_W 32

// AR address width
`define BEATS_ADDR_W 32

// Longest burst a client may ask for
`define BEATS_MAX_BURST 16

// Almost-full fires when free space drops to this
`define BEATS_ALMOST_FULL_MARGIN 4

// Almost-empty fires when reserved beats drop to this
`define BEATS_ALMOST_EMPTY_MARGIN 4

`endif

// File: rtl/beats_pkg.sv
`include "beats_settings.svh"

package beats_pkg;

        // ----------------------------------------------------------
        // Burst length and size
        // ----------------------------------------------------------

        // AXI length field, beats minus one
        typedef logic [7:0] beat_len_t;

        // Beat count of one allocation
        typedef logic [7:0] beat_size_t;

        // ----------------------------------------------------------
        // Buffer bookkeeping
        // ----------------------------------------------------------

        // Occupancy or free space, 0 up to full depth
        typedef logic [$clog2(`BEATS_DEPTH):0] occ_t;

        // Pointer with extra wrap bit on top
        typedef logic [$clog2(`BEATS_DEPTH):0] ptr_t;

        // ----------------------------------------------------------
        // Payload
        // ----------------------------------------------------------
        typedef logic [`BEATS_ADDR_W-1:0] addr_t;
        typedef logic [`BEATS_DATA_W-1:0] data_t;

endpackage

// File: rtl/beat_alloc_ctrl.sv
`timescale 1ns/1ps

`include "beats_settings.svh"

module beat_alloc_ctrl (
        input  logic                  axi_aclk,
        input  logic                  arst_n,

        // Reservation request from the burst stage
        input  logic                  alloc_valid,
        input  beats_pkg::beat_size_t alloc_size,
        output logic                  alloc_ready,

        // One slot back per consumer pop
        input  logic                  beat_release,

        // Registered status
        output beats_pkg::occ_t       space_free,
        output logic                  full,
        output logic                  almost_full,
        output logic                  empty,
        output logic                  almost_empty
);
        import beats_pkg::*;

        // Full depth in occupancy width
        localparam occ_t DEPTH_OCC = occ_t'(`BEATS_DEPTH);

        // ----------------------------------------------------------
        // Pointers and next-state values
        // ----------------------------------------------------------

        // Allocation side, moves by whole bursts
        ptr_t alloc_ptr;
        ptr_t alloc_ptr_nxt;

        // Release side, moves one beat at a time
        ptr_t rel_ptr;
        ptr_t rel_ptr_nxt;

        logic grant;
        occ_t reserved_nxt;
        occ_t free_nxt;

        // Grant only if the whole burst fits in current free space
        assign alloc_ready = alloc_size <= beat_size_t'(space_free);
        assign grant       = alloc_valid && alloc_ready;

        // Size never exceeds depth once granted, so truncation is lossless
        assign alloc_ptr_nxt = grant ? alloc_ptr + ptr_t'(alloc_size) : alloc_ptr;
        assign rel_ptr_nxt   = beat_release ? rel_ptr + ptr_t'(1) : rel_ptr;

        // Wrap bit makes the difference span 0..DEPTH
        assign reserved_nxt = occ_t'(alloc_ptr_nxt - rel_ptr_nxt);
        assign free_nxt     = DEPTH_OCC - reserved_nxt;

        // ----------------------------------------------------------
        // Pointer registers
        // ----------------------------------------------------------
        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        alloc_ptr <= '0;
                        rel_ptr   <= '0;
                end else begin
                        // Grant and release in one cycle both land
                        alloc_ptr <= alloc_ptr_nxt;
                        rel_ptr   <= rel_ptr_nxt;
                end
        end

        // ----------------------------------------------------------
        // Status registers
        // ----------------------------------------------------------
        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        // Nothing reserved out of reset
                        space_free   <= DEPTH_OCC;
                        full         <= 1'b0;
                        almost_full  <= 1'b0;
                        empty        <= 1'b1;
                        almost_empty <= 1'b1;
                end else begin
                        space_free <= free_nxt;

                        // Every slot promised to an issued burst
                        full  <= reserved_nxt == DEPTH_OCC;
                        empty <= reserved_nxt == '0;

                        // Early warnings
                        almost_full  <= free_nxt <= occ_t'(`BEATS_ALMOST_FULL_MARGIN);
                        almost_empty <= reserved_nxt <= occ_t'(`BEATS_ALMOST_EMPTY_MARGIN);
                end
        end

endmodule

// File: rtl/burst_reserve.sv
`timescale 1ns/1ps

module burst_reserve (
        input  logic                  axi_aclk,
        input  logic                  arst_n,

        // Client burst request
        input  logic                  req_valid,
        input  beats_pkg::addr_t      req_addr,
        input  beats_pkg::beat_len_t  req_len,
        output logic                  req_ready,

        // Reservation toward the allocation controller
        output logic                  alloc_valid,
        output beats_pkg::beat_size_t alloc_size,
        input  logic                  alloc_ready,

        // AXI AR channel
        output logic                  ar_valid,
        output beats_pkg::addr_t      ar_addr,
        output beats_pkg::beat_len_t  ar_len,
        input  logic                  ar_ready
);
        import beats_pkg::*;

        // Idle, waiting for space, then waiting for AR accept
        typedef enum logic [1:0] {
                ST_IDLE,
                ST_RESERVE,
                ST_ISSUE
        } state_t;

        state_t    state;
        addr_t     addr_q;
        beat_len_t len_q;

        // ----------------------------------------------------------
        // FSM
        // ----------------------------------------------------------
        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        state <= ST_IDLE;
                end else begin
                        case (state)
                        ST_IDLE: begin
                                if (req_valid) begin
                                        state <= ST_RESERVE;
                                end
                        end
                        ST_RESERVE: begin
                                // Space granted, AR may go out next cycle
                                if (alloc_ready) begin
                                        state <= ST_ISSUE;
                                end
                        end
                        ST_ISSUE: begin
                                if (ar_ready) begin
                                        state <= ST_IDLE;
                                end
                        end
                        default: begin
                                state <= ST_IDLE;
                        end
                        endcase
                end
        end

        // Request held until AR handshake
        always_ff @(posedge axi_aclk) begin
                if (req_valid && req_ready) begin
                        addr_q <= req_addr;
                        len_q  <= req_len;
                end
        end

        // ----------------------------------------------------------
        // Outputs decoded from state
        // ----------------------------------------------------------
        assign req_ready   = state == ST_IDLE;
        assign alloc_valid = state == ST_RESERVE;
        assign ar_valid    = state == ST_ISSUE;

        // AXI len is beats minus one
        assign alloc_size = beat_size_t'(len_q) + beat_size_t'(1);

        assign ar_addr = addr_q;
        assign ar_len  = len_q;

endmodule

// File: rtl/beat_buffer.sv
`timescale 1ns/1ps

`include "beats_settings.svh"

module beat_buffer (
        input  logic             axi_aclk,
        input  logic             arst_n,

        // R data, always accepted
        input  logic             r_valid,
        input  beats_pkg::data_t r_data,

        // Consumer side
        output logic             out_valid,
        output beats_pkg::data_t out_data,
        input  logic             out_ready,

        // Pulse per popped beat
        output logic             beat_release
);
        import beats_pkg::*;

        // Index bits below the wrap bit
        localparam int IDX_W = $clog2(`BEATS_DEPTH);

        // ----------------------------------------------------------
        // Storage and pointers
        // ----------------------------------------------------------
        data_t mem [`BEATS_DEPTH];

        ptr_t wr_ptr;
        ptr_t rd_ptr;
        logic pop;

        // Beat visible the cycle after its write edge
        assign out_valid = wr_ptr != rd_ptr;
        assign out_data  = mem[rd_ptr[IDX_W-1:0]];

        assign pop          = out_valid && out_ready;
        assign beat_release = pop;

        // ----------------------------------------------------------
        // Write side
        // ----------------------------------------------------------

        // Room was reserved before AR, so no overflow check here
        always_ff @(posedge axi_aclk) begin
                if (r_valid) begin
                        mem[wr_ptr[IDX_W-1:0]] <= r_data;
                end
        end

        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        wr_ptr <= '0;
                end else if (r_valid) begin
                        wr_ptr <= wr_ptr + ptr_t'(1);
                end
        end

        // ----------------------------------------------------------
        // Read side
        // ----------------------------------------------------------

        // Head beat stays put while out_ready is low
        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        rd_ptr <= '0;
                end else if (pop) begin
                        rd_ptr <= rd_ptr + ptr_t'(1);
                end
        end

endmodule

// File: rtl/beat_fetch_top.sv
`timescale 1ns/1ps

module beat_fetch_top (
        input  logic                  axi_aclk,
        input  logic                  arst_n,

        // Client
        input  logic                  req_valid,
        input  beats_pkg::addr_t      req_addr,
        input  beats_pkg::beat_len_t  req_len,
        output logic                  req_ready,

        // AXI AR
        output logic                  ar_valid,
        output beats_pkg::addr_t      ar_addr,
        output beats_pkg::beat_len_t  ar_len,
        input  logic                  ar_ready,

        // AXI R, no ready needed
        input  logic                  r_valid,
        input  beats_pkg::data_t      r_data,

        // Consumer
        output logic                  out_valid,
        output beats_pkg::data_t      out_data,
        input  logic                  out_ready,

        // Reservation status
        output beats_pkg::occ_t       space_free,
        output logic                  full,
        output logic                  almost_full,
        output logic                  empty,
        output logic                  almost_empty
);
        import beats_pkg::*;

        // ----------------------------------------------------------
        // Internal links
        // ----------------------------------------------------------
        logic       alloc_valid;
        logic       alloc_ready;
        beat_size_t alloc_size;
        logic       beat_release;

        // Request hold and AR issue
        burst_reserve u_burst_reserve (
                .axi_aclk    (axi_aclk),
                .arst_n      (arst_n),
                .req_valid   (req_valid),
                .req_addr    (req_addr),
                .req_len     (req_len),
                .req_ready   (req_ready),
                .alloc_valid (alloc_valid),
                .alloc_size  (alloc_size),
                .alloc_ready (alloc_ready),
                .ar_valid    (ar_valid),
                .ar_addr     (ar_addr),
                .ar_len      (ar_len),
                .ar_ready    (ar_ready)
        );

        // Space bookkeeping without data
        beat_alloc_ctrl u_beat_alloc_ctrl (
                .axi_aclk     (axi_aclk),
                .arst_n       (arst_n),
                .alloc_valid  (alloc_valid),
                .alloc_size   (alloc_size),
                .alloc_ready  (alloc_ready),
                .beat_release (beat_release),
                .space_free   (space_free),
                .full         (full),
                .almost_full  (almost_full),
                .empty        (empty),
                .almost_empty (almost_empty)
        );

        // R beat storage
        beat_buffer u_beat_buffer (
                .axi_aclk     (axi_aclk),
                .arst_n       (arst_n),
                .r_valid      (r_valid),
                .r_data       (r_data),
                .out_valid    (out_valid),
                .out_data     (out_data),
                .out_ready    (out_ready),
                .beat_release (beat_release)
        );

endmodule

// File: verif/tb_beat_fetch.sv
`timescale 1ns/1ps

`include "beats_settings.svh"

module tb_beat_fetch;
        import beats_pkg::*;

        // Cycle budget for any single wait
        localparam int WAIT_LIMIT = 4000;
        localparam data_t DATA_BASE = 32'hd000_0000;

        logic axi_aclk;
        logic arst_n;
        logic req_valid;
        addr_t req_addr;
        beat_len_t req_len;
        logic req_ready;
        logic ar_valid;
        addr_t ar_addr;
        beat_len_t ar_len;
        logic ar_ready;
        logic r_valid;
        data_t r_data;
        logic out_valid;
        data_t out_data;
        logic out_ready;
        occ_t space_free;
        logic full;
        logic almost_full;
        logic empty;
        logic almost_empty;

        // Scoreboard state, owned by the monitor
        int model_free = `BEATS_DEPTH;
        int beats_issued = 0;
        int beats_popped = 0;
        logic pop_pending = 1'b0;
        logic ar_valid_q = 1'b0;
        addr_t req_addr_q[$];
        beat_len_t req_len_q[$];

        // Slave and consumer state
        int beats_sent;
        logic hold_pops;

        beat_fetch_top UUT (.*);

        initial begin
                axi_aclk = 1'b0;
                forever #10 axi_aclk = ~axi_aclk;
        end

        // ----------------------------------------------------------
        // Failure reporting
        // ----------------------------------------------------------
        task automatic abort_run();
                $display("ERRORS FOUND");
                $fatal(1, "stopped at first failing check");
        endtask

        task automatic compare_value(input string name, input longint got, input longint exp);
                assert (got == exp) else begin
                        $display("MISMATCH time=%0t signal=%s got=%0h expected=%0h",
                                 $time, name, got, exp);
                        abort_run();
                end
        endtask

        // Stable sample point, well clear of both edges
        task automatic step();
                @(posedge axi_aclk);
                #5;
        endtask

        // ----------------------------------------------------------
        // Client side
        // ----------------------------------------------------------
        task automatic send_req(input addr_t addr, input beat_len_t len);
                int cycles;
                cycles = 0;
                @(posedge axi_aclk);
                #2;
                req_valid = 1'b1;
                req_addr  = addr;
                req_len   = len;
                #3;
                while (!req_ready) begin
                        cycles++;
                        if (cycles > WAIT_LIMIT) begin
                                $display("Timeout: client request never accepted");
                                abort_run();
                        end
                        step();
                end
                // Handshake lands on this edge
                @(posedge axi_aclk);
                #2;
                req_valid = 1'b0;
        endtask

        task automatic wait_drained();
                int cycles;
                cycles = 0;
                step();
                while (!(req_ready && !ar_valid && req_addr_q.size() == 0 &&
                         beats_popped == beats_issued &&
                         space_free == occ_t'(`BEATS_DEPTH))) begin
                        cycles++;
                        if (cycles > WAIT_LIMIT) begin
                                $display("Timeout: free space never returned to full depth");
                                abort_run();
                        end
                        step();
                end
        endtask

        task automatic wait_until_full();
                int cycles;
                cycles = 0;
                step();
                while (!full) begin
                        cycles++;
                        if (cycles > WAIT_LIMIT) begin
                                $display("Timeout: reservations never filled the buffer");
                                abort_run();
                        end
                        step();
                end
        endtask

        // ----------------------------------------------------------
        // AXI slave and consumer
        // ----------------------------------------------------------
        initial begin
                r_valid    = 1'b0;
                r_data     = '0;
                ar_ready   = 1'b0;
                out_ready  = 1'b0;
                beats_sent = 0;
                forever begin
                        @(posedge axi_aclk);
                        #2;
                        ar_ready  = ($urandom_range(0, 1) == 1);
                        out_ready = !hold_pops && ($urandom_range(0, 3) != 0);
                        // Counting data, only for bursts already accepted on AR
                        if (beats_issued > beats_sent && $urandom_range(0, 3) != 0) begin
                                r_valid = 1'b1;
                                r_data  = DATA_BASE + data_t'(beats_sent);
                                beats_sent++;
                        end else begin
                                r_valid = 1'b0;
                        end
                end
        end

        // ----------------------------------------------------------
        // Monitor, sampled at the falling edge
        // ----------------------------------------------------------
        always @(negedge axi_aclk) begin
                if (arst_n) begin
                        // Pop seen last cycle freed one slot at the edge
                        model_free = model_free + (pop_pending ? 1 : 0);
                        // Rising AR means the reservation landed at the edge
                        if (ar_valid && !ar_valid_q) begin
                                assert (model_free >= int'(ar_len) + 1) else begin
                                        $display("AR raised for %0d beats with only %0d free",
                                                 int'(ar_len) + 1, model_free);
                                        abort_run();
                                end
                                model_free = model_free - (int'(ar_len) + 1);
                        end
                        compare_value("space_free", longint'(space_free), longint'(model_free));
                        compare_value("full", longint'(full), longint'(model_free == 0));
                        compare_value("empty", longint'(empty),
                                      longint'(model_free == `BEATS_DEPTH));
                        compare_value("almost_full", longint'(almost_full),
                                      longint'(model_free <= `BEATS_ALMOST_FULL_MARGIN));
                        compare_value("almost_empty", longint'(almost_empty),
                                      longint'(`BEATS_DEPTH - model_free <=
                                               `BEATS_ALMOST_EMPTY_MARGIN));
                        if (req_valid && req_ready) begin
                                req_addr_q.push_back(req_addr);
                                req_len_q.push_back(req_len);
                        end
                        if (ar_valid && ar_ready) begin
                                if (req_addr_q.size() == 0) begin
                                        $display("AR handshake with no client request pending");
                                        abort_run();
                                end else begin
                                        compare_value("ar_addr", longint'(ar_addr),
                                                      longint'(req_addr_q[0]));
                                        compare_value("ar_len", longint'(ar_len),
                                                      longint'(req_len_q[0]));
                                        void'(req_addr_q.pop_front());
                                        void'(req_len_q.pop_front());
                                        beats_issued = beats_issued + int'(ar_len) + 1;
                                end
                        end
                        // No beat lost or repeated
                        if (out_valid && out_ready) begin
                                compare_value("out_data", longint'(out_data),
                                              longint'(DATA_BASE + data_t'(beats_popped)));
                                beats_popped++;
                        end
                        pop_pending = out_valid && out_ready;
                        ar_valid_q  = ar_valid;
                end
        end

        // ----------------------------------------------------------
        // Main sequence
        // ----------------------------------------------------------
        initial begin
                void'($urandom(32'h059050ec));
                arst_n    = 1'b0;
                req_valid = 1'b0;
                req_addr  = '0;
                req_len   = '0;
                hold_pops = 1'b0;
                repeat (3) @(posedge axi_aclk);
                #2;
                arst_n = 1'b1;
                #3;

                // Out of reset
                compare_value("space_free", longint'(space_free), longint'(`BEATS_DEPTH));
                compare_value("empty", longint'(empty), 1);
                compare_value("full", longint'(full), 0);
                compare_value("req_ready", longint'(req_ready), 1);
                compare_value("ar_valid", longint'(ar_valid), 0);
                compare_value("out_valid", longint'(out_valid), 0);

                // Random lengths with consumer gaps
                for (int i = 0; i < 24; i++) begin
                        send_req(addr_t'($urandom & 32'hffff_fffc),
                                 beat_len_t'($urandom_range(0, `BEATS_MAX_BURST - 1)));
                end
                wait_drained();

                // Consumer stalled, fifth long burst cannot be reserved
                hold_pops = 1'b1;
                for (int i = 0; i < 5; i++) begin
                        send_req(addr_t'($urandom & 32'hffff_fffc),
                                 beat_len_t'(`BEATS_MAX_BURST - 1));
                end
                wait_until_full();
                repeat (20) step();
                compare_value("ar_valid", longint'(ar_valid), 0);

                // Pops resume and everything drains
                hold_pops = 1'b0;
                wait_drained();

                $display("NO ERRORS");
                $finish;
        end

endmodule

// File: compile.f
+incdir+rtl
rtl/beats_pkg.sv
rtl/beat_alloc_ctrl.sv
rtl/burst_reserve.sv
rtl/beat_buffer.sv
rtl/beat_fetch_top.sv
verif/tb_beat_fetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# Build the testbench with the RTL
verilator --binary --timing --assert \
        --top-module tb_beat_fetch \
        -f compile.f

# Run and keep the log
./obj_dir/Vtb_beat_fetch 2>&1 | tee sim.log

# A missing pass line fails the script
grep -qx "NO ERRORS" sim.log
